// File: verilog/asic_pkg.sv
package asic_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] addr_t;
    typedef logic [4:0]  pen_t;   // Pen number or hardware colour

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    // I/O map
    localparam byte_t GA_PAGE          = 8'h7F;
    localparam addr_t ROMSEL_ADDR      = 16'hDF00;
    localparam addr_t CRTC_SELECT_ADDR = 16'hBC00;
    localparam addr_t CRTC_DATA_ADDR   = 16'hBD00;

    localparam byte_t GA_PEN_LAST     = 8'h10;
    localparam byte_t GA_PEN_READ     = 8'h10;
    localparam byte_t GA_MRER_PORT    = 8'h89;
    localparam byte_t GA_RAMCFG_FIRST = 8'hC0;
    localparam byte_t GA_RAMCFG_LAST  = 8'hC7;

    // ASIC page at 4000h-7FFFh, offsets relative to 4000h
    localparam logic [1:0]  ASIC_PAGE_SEL = 2'b01;
    localparam logic [13:0] PALETTE_BASE  = 14'h2400;
    localparam logic [13:0] PALETTE_SIZE  = 14'h0040;
    localparam logic [13:0] DMA_BASE      = 14'h2C00;
    localparam logic [13:0] DMA_SIZE      = 14'h0010;
    localparam logic [13:0] DCSR_OFFSET   = 14'h2C0F;

    localparam int CRTC_STD_REGS  = 16;  // Writable while locked
    localparam int CRTC_REG_COUNT = 32;
    localparam int ACID_LENGTH    = 16;

    typedef logic [CRTC_REG_COUNT-1:0][7:0] crtc_file_t;

    localparam byte_t ACID_SEQUENCE [ACID_LENGTH] = '{
        8'haa, 8'h00, 8'hff, 8'h77, 8'hb3, 8'h51, 8'ha8, 8'hd4,
        8'h62, 8'h39, 8'h9c, 8'h46, 8'h2b, 8'h15, 8'h8a, 8'hcd
    };

    // Red, green, blue levels per hardware colour index
    localparam rgb_t HW_COLOUR_RGB [32] = '{
        12'h666, 12'h666, 12'h0F6, 12'hFF6, 12'h006, 12'hF06, 12'h066, 12'hF66,
        12'hF06, 12'hFF6, 12'hFF0, 12'hFFF, 12'hF00, 12'hF0F, 12'hF60, 12'hF6F,
        12'h006, 12'h0F6, 12'h0F0, 12'h0FF, 12'h000, 12'h00F, 12'h060, 12'h06F,
        12'h606, 12'h6F6, 12'h6F0, 12'h6FF, 12'h600, 12'h60F, 12'h660, 12'h66F
    };

endpackage

// File: verilog/asic_bus_decode.sv
module asic_bus_decode (
    input  asic_pkg::addr_t cpu_addr,
    input  logic            cpu_wr,
    input  logic            cpu_rd,
    output logic            ga_wr,
    output logic            ga_rd,
    output logic            romsel_wr,
    output logic            crtc_select_wr,
    output logic            crtc_data_wr,
    output logic            page_wr,
    output logic            page_rd,
    output logic [13:0]     page_offset
);
    import asic_pkg::*;

    logic ga_hit;
    logic page_hit;

    assign ga_hit   = (cpu_addr[15:8] == GA_PAGE);         // Any port 7Fxx
    assign page_hit = (cpu_addr[15:14] == ASIC_PAGE_SEL);  // 4000h-7FFFh

    assign ga_wr = cpu_wr && ga_hit;
    assign ga_rd = cpu_rd && ga_hit;

    // Full address match for the single-port devices
    assign romsel_wr      = cpu_wr && (cpu_addr == ROMSEL_ADDR);
    assign crtc_select_wr = cpu_wr && (cpu_addr == CRTC_SELECT_ADDR);
    assign crtc_data_wr   = cpu_wr && (cpu_addr == CRTC_DATA_ADDR);

    assign page_wr     = cpu_wr && page_hit;
    assign page_rd     = cpu_rd && page_hit;
    assign page_offset = cpu_addr[13:0];

endmodule

// File: verilog/acid_unlock.sv
module acid_unlock (
    input  logic            clk_sys,
    input  logic            reset,
    input  logic            crtc_select_wr,
    input  asic_pkg::byte_t data,
    output logic            acid_unlocked
);
    import asic_pkg::*;

    localparam int POS_W = $clog2(ACID_LENGTH);

    logic [POS_W-1:0] pos;      // Next sequence byte expected
    byte_t            prev_select;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pos           <= '0;
            prev_select   <= '0;
            acid_unlocked <= 1'b0;
        end else if (crtc_select_wr) begin
            prev_select <= data;
            // Repeated select bytes do not count
            if (!acid_unlocked && data != prev_select) begin
                if (data == ACID_SEQUENCE[pos]) begin
                    if (pos == POS_W'(ACID_LENGTH - 1)) begin
                        acid_unlocked <= 1'b1;  // Sticky until reset
                        pos           <= '0;
                    end else begin
                        pos <= pos + 1'b1;
                    end
                end else begin
                    pos <= '0;  // Mismatch restarts the hunt
                end
            end
        end
    end

endmodule

// File: verilog/crtc_regs.sv
module crtc_regs (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  logic                 crtc_select_wr,
    input  logic                 crtc_data_wr,
    input  asic_pkg::byte_t      data,
    input  logic                 acid_unlocked,
    output asic_pkg::byte_t      crtc_select,
    output asic_pkg::crtc_file_t crtc_file,
    output asic_pkg::byte_t      asic_data_out,
    output logic                 asic_data_out_en
);
    import asic_pkg::*;

    logic [4:0] reg_index;
    logic       write_allowed;

    assign reg_index = crtc_select[4:0];

    // Upper half of the file only opens after the ACID unlock
    assign write_allowed = (crtc_select < CRTC_STD_REGS) ||
                           (acid_unlocked && crtc_select < CRTC_REG_COUNT);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            crtc_select <= '0;
            crtc_file   <= '0;
        end else begin
            if (crtc_select_wr)
                crtc_select <= data;
            if (crtc_data_wr && write_allowed)
                crtc_file[reg_index] <= data;
        end
    end

    // Echo of each CRTC access, one cycle later
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            asic_data_out    <= '0;
            asic_data_out_en <= 1'b0;
        end else if (crtc_select_wr) begin
            asic_data_out    <= data;                  // New select value
            asic_data_out_en <= 1'b1;
        end else if (crtc_data_wr) begin
            asic_data_out    <= crtc_file[reg_index];  // Value before the write
            asic_data_out_en <= 1'b1;
        end else begin
            asic_data_out    <= 8'hFF;
            asic_data_out_en <= 1'b0;
        end
    end

endmodule

// File: verilog/gate_array_regs.sv
module gate_array_regs (
    input  logic            clk_sys,
    input  logic            reset,
    input  logic            ga_wr,
    input  logic            ga_rd,
    input  logic            romsel_wr,
    input  asic_pkg::byte_t port,       // Low address byte
    input  asic_pkg::byte_t data,
    output asic_pkg::byte_t ram_config,
    output asic_pkg::byte_t rom_config,
    output asic_pkg::byte_t rom_select,
    output asic_pkg::pen_t  current_pen,
    output asic_pkg::pen_t  pen_ink,
    output logic            read_hit,
    output asic_pkg::byte_t read_data
);
    import asic_pkg::*;

    pen_t ink [16];  // Ink palette, one entry per pen

    logic pen_port;
    logic ramcfg_port;

    assign pen_port    = (port <= GA_PEN_LAST);
    assign ramcfg_port = (port >= GA_RAMCFG_FIRST) && (port <= GA_RAMCFG_LAST);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            current_pen <= '0;
            rom_config  <= '0;
            ram_config  <= '0;
            rom_select  <= '0;
            for (int i = 0; i < 16; i++)
                ink[i] <= '0;
        end else begin
            if (ga_wr) begin
                if (pen_port) begin
                    // Top bits 00 pick a pen, anything else sets its ink
                    if (data[7:6] == 2'b00)
                        current_pen <= data[4:0];
                    else
                        ink[current_pen[3:0]] <= data[4:0];
                end
                if (port == GA_MRER_PORT)
                    rom_config <= data;
                if (ramcfg_port)
                    ram_config <= port;  // Config is carried in the port number
            end
            if (romsel_wr)
                rom_select <= data;
        end
    end

    assign pen_ink = ink[current_pen[3:0]];

    always_comb begin
        read_hit  = 1'b0;
        read_data = 8'hFF;
        if (ga_rd) begin
            case (port)
                GA_MRER_PORT: begin
                    read_hit  = 1'b1;
                    read_data = rom_config;
                end
                GA_RAMCFG_FIRST: begin
                    read_hit  = 1'b1;
                    read_data = ram_config;
                end
                GA_PEN_READ: begin
                    read_hit  = 1'b1;
                    read_data = {3'b000, current_pen[4] ? pen_ink : current_pen};
                end
                default: ;
            endcase
        end
    end

endmodule

// File: verilog/asic_page_regs.sv
module asic_page_regs (
    input  logic            clk_sys,
    input  logic            reset,
    input  logic            page_wr,
    input  logic            page_rd,
    input  logic [13:0]     page_offset,
    input  asic_pkg::byte_t data,
    output logic            read_hit,
    output asic_pkg::byte_t read_data
);
    import asic_pkg::*;

    localparam int ENTRIES = PALETTE_SIZE / 2;

    // Byte 0 holds red and blue nibbles, byte 1 holds green
    byte_t pal_lo [ENTRIES];
    byte_t pal_hi [ENTRIES];
    byte_t dcsr;

    logic        pal_hit;
    logic        dma_hit;
    logic [13:0] pal_rel;
    logic [4:0]  pal_index;
    rgb_t        lookup;

    assign pal_hit = (page_offset >= PALETTE_BASE) &&
                     (page_offset < PALETTE_BASE + PALETTE_SIZE);
    assign dma_hit = (page_offset >= DMA_BASE) && (page_offset < DMA_BASE + DMA_SIZE);

    assign pal_rel   = page_offset - PALETTE_BASE;
    assign pal_index = pal_rel[5:1];
    assign lookup    = HW_COLOUR_RGB[data[4:0]];

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dcsr <= '0;
            for (int i = 0; i < ENTRIES; i++) begin
                pal_lo[i] <= '0;
                pal_hi[i] <= '0;
            end
        end else if (page_wr) begin
            if (pal_hit) begin
                if (!pal_rel[0]) begin
                    // Even byte takes a hardware colour index
                    pal_lo[pal_index] <= {lookup.red, lookup.blue};
                    pal_hi[pal_index] <= {4'h0, lookup.green};
                end else begin
                    pal_hi[pal_index] <= data;
                end
            end
            if (page_offset == DCSR_OFFSET)
                dcsr <= data;
        end
    end

    always_comb begin
        read_hit  = 1'b0;
        read_data = 8'hFF;
        if (page_rd && pal_hit) begin
            read_hit  = 1'b1;
            read_data = pal_rel[0] ? {4'h0, pal_hi[pal_index][3:0]} : pal_lo[pal_index];
        end else if (page_rd && dma_hit) begin
            read_hit  = 1'b1;
            read_data = dcsr;  // Whole DMA window reads back DCSR
        end
    end

endmodule

// File: verilog/asic_registers.sv
module asic_registers (
    input  logic                 clk_sys,
    input  logic                 reset,
    input  asic_pkg::addr_t      cpu_addr,
    input  asic_pkg::byte_t      cpu_data_in,
    input  logic                 cpu_wr,
    input  logic                 cpu_rd,
    output asic_pkg::byte_t      cpu_data_out,
    output logic                 cpu_data_out_en,
    output asic_pkg::byte_t      asic_data_out,
    output logic                 asic_data_out_en,
    output asic_pkg::byte_t      ram_config,
    output asic_pkg::byte_t      rom_config,
    output asic_pkg::byte_t      rom_select,
    output asic_pkg::pen_t       current_pen,
    output asic_pkg::pen_t       pen_ink,
    output asic_pkg::byte_t      crtc_select,
    output asic_pkg::crtc_file_t crtc_file,
    output logic                 acid_unlocked
);

    logic        ga_wr, ga_rd, romsel_wr;
    logic        crtc_select_wr, crtc_data_wr;
    logic        page_wr, page_rd;
    logic [13:0] page_offset;

    logic        ga_read_hit, page_read_hit;
    logic [7:0]  ga_read_data, page_read_data;

    asic_bus_decode u_decode (
        .cpu_addr, .cpu_wr, .cpu_rd,
        .ga_wr, .ga_rd, .romsel_wr, .crtc_select_wr, .crtc_data_wr,
        .page_wr, .page_rd, .page_offset
    );

    acid_unlock u_acid (
        .clk_sys, .reset, .crtc_select_wr, .data(cpu_data_in), .acid_unlocked
    );

    crtc_regs u_crtc (
        .clk_sys, .reset, .crtc_select_wr, .crtc_data_wr, .data(cpu_data_in),
        .acid_unlocked, .crtc_select, .crtc_file, .asic_data_out, .asic_data_out_en
    );

    gate_array_regs u_ga (
        .clk_sys, .reset, .ga_wr, .ga_rd, .romsel_wr,
        .port(cpu_addr[7:0]), .data(cpu_data_in),
        .ram_config, .rom_config, .rom_select, .current_pen, .pen_ink,
        .read_hit(ga_read_hit), .read_data(ga_read_data)
    );

    asic_page_regs u_page (
        .clk_sys, .reset, .page_wr, .page_rd, .page_offset, .data(cpu_data_in),
        .read_hit(page_read_hit), .read_data(page_read_data)
    );

    // Registered read-back, FF when nothing answers
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            cpu_data_out    <= '0;
            cpu_data_out_en <= 1'b0;
        end else if (ga_read_hit) begin
            cpu_data_out    <= ga_read_data;
            cpu_data_out_en <= 1'b1;
        end else if (page_read_hit) begin
            cpu_data_out    <= page_read_data;
            cpu_data_out_en <= 1'b1;
        end else begin
            cpu_data_out    <= 8'hFF;
            cpu_data_out_en <= 1'b0;
        end
    end

endmodule

// File: test/asic_vectors.svh
// Each row holds test name, operation, address, data, expected value and output compared
// For OP_CHK rows on the CRTC file the address column holds the register index
// For OP_SELECTS rows the data column is how many select bytes to send

// Bytes sent in order to the CRTC select port by the OP_SELECTS rows
localparam logic [7:0] SELECT_BYTES [34] = '{
    8'haa, 8'h00, 8'h12, 8'hff, 8'h77, 8'hb3, 8'h51, 8'ha8, 8'hd4, 8'h62,
    8'h39, 8'h9c, 8'h46, 8'h2b, 8'h15, 8'h8a, 8'hcd,
    8'haa, 8'h00, 8'hff, 8'h77, 8'h77, 8'hb3, 8'h51, 8'ha8, 8'hd4, 8'h62,
    8'h39, 8'h9c, 8'h46, 8'h2b, 8'h15, 8'h8a,
    8'hcd
};

task automatic build_table();
    add_row("mem_config", OP_WR,  16'h7F89, 8'h0C, 8'h00, SEL_NONE);
    add_row("mem_config", OP_WR,  16'h7FC5, 8'h00, 8'h00, SEL_NONE);
    add_row("mem_config", OP_WR,  16'hDF00, 8'h07, 8'h00, SEL_NONE);
    add_row("mem_config", OP_CHK, 16'h0000, 8'h00, 8'h0C, SEL_ROM_CFG);
    add_row("mem_config", OP_CHK, 16'h0000, 8'h00, 8'hC5, SEL_RAM_CFG);
    add_row("mem_config", OP_CHK, 16'h0000, 8'h00, 8'h07, SEL_ROM_SEL);
    add_row("mem_config", OP_RD,  16'h7F89, 8'h00, 8'h0C, SEL_NONE);
    add_row("mem_config", OP_RD,  16'h7FC0, 8'h00, 8'hC5, SEL_NONE);
    // Pen 3, then ink 14h with 01 in the top bits
    add_row("pen_ink", OP_WR,  16'h7F00, 8'h03, 8'h00, SEL_NONE);
    add_row("pen_ink", OP_WR,  16'h7F00, 8'h54, 8'h00, SEL_NONE);
    add_row("pen_ink", OP_CHK, 16'h0000, 8'h00, 8'h03, SEL_PEN);
    add_row("pen_ink", OP_CHK, 16'h0000, 8'h00, 8'h14, SEL_INK);
    add_row("pen_ink", OP_WR,  16'h7F00, 8'h13, 8'h00, SEL_NONE);
    add_row("pen_ink", OP_RD,  16'h7F10, 8'h00, 8'h14, SEL_NONE);  // Ink of entry 3
    add_row("pen_ink", OP_WR,  16'h7F00, 8'h05, 8'h00, SEL_NONE);
    add_row("pen_ink", OP_RD,  16'h7F10, 8'h00, 8'h05, SEL_NONE);  // Pen number
    // Register 20 is locked, register 5 is not
    add_row("crtc_lock", OP_WR_ECHO, 16'hBC00, 8'h14, 8'h14, SEL_NONE);
    add_row("crtc_lock", OP_WR_ECHO, 16'hBD00, 8'h77, 8'h00, SEL_NONE);
    add_row("crtc_lock", OP_CHK,     16'd20,   8'h00, 8'h00, SEL_CRTC);
    add_row("crtc_lock", OP_WR_ECHO, 16'hBC00, 8'h05, 8'h05, SEL_NONE);
    add_row("crtc_lock", OP_CHK,     16'h0000, 8'h00, 8'h05, SEL_SELECT);
    add_row("crtc_lock", OP_WR_ECHO, 16'hBD00, 8'h42, 8'h00, SEL_NONE);
    add_row("crtc_lock", OP_CHK,     16'd5,    8'h00, 8'h42, SEL_CRTC);
    add_row("crtc_lock", OP_WR_ECHO, 16'hBD00, 8'h43, 8'h42, SEL_NONE);  // Old value echoed
    // Broken start that would finish the sequence if the count kept going
    add_row("acid_unlock", OP_SELECTS, 16'hBC00, 8'd17,  8'h00, SEL_NONE);
    add_row("acid_unlock", OP_CHK,     16'h0000, 8'h00,  8'h00, SEL_UNLOCK);
    // Full sequence with one repeated byte, last byte held back
    add_row("acid_unlock", OP_SELECTS, 16'hBC00, 8'd16,  8'h00, SEL_NONE);
    add_row("acid_unlock", OP_CHK,     16'h0000, 8'h00,  8'h00, SEL_UNLOCK);
    add_row("acid_unlock", OP_SELECTS, 16'hBC00, 8'd1,   8'h00, SEL_NONE);
    add_row("acid_unlock", OP_CHK,     16'h0000, 8'h00,  8'h01, SEL_UNLOCK);
    add_row("acid_unlock", OP_WR,      16'hBC00, 8'h14,  8'h00, SEL_NONE);
    add_row("acid_unlock", OP_WR,      16'hBD00, 8'h99,  8'h00, SEL_NONE);
    add_row("acid_unlock", OP_CHK,     16'd20,   8'h00,  8'h99, SEL_CRTC);
    // Colour 0Ch is red F, green 0, blue 0
    add_row("palette", OP_WR, 16'h6410, 8'h0C, 8'h00, SEL_NONE);
    add_row("palette", OP_RD, 16'h6410, 8'h00, 8'hF0, SEL_NONE);
    add_row("palette", OP_RD, 16'h6411, 8'h00, 8'h00, SEL_NONE);
    add_row("palette", OP_WR, 16'h6411, 8'h5A, 8'h00, SEL_NONE);
    add_row("palette", OP_RD, 16'h6411, 8'h00, 8'h0A, SEL_NONE);
    // Colour 02h is red 0, green F, blue 6
    add_row("palette", OP_WR, 16'h6410, 8'h02, 8'h00, SEL_NONE);
    add_row("palette", OP_RD, 16'h6410, 8'h00, 8'h06, SEL_NONE);
    add_row("palette", OP_RD, 16'h6411, 8'h00, 8'h0F, SEL_NONE);
    add_row("dcsr", OP_WR, 16'h6C0F, 8'h83, 8'h00, SEL_NONE);
    add_row("dcsr", OP_RD, 16'h6C00, 8'h00, 8'h83, SEL_NONE);
    add_row("dcsr", OP_RD, 16'h6C0F, 8'h00, 8'h83, SEL_NONE);
    add_row("unmapped", OP_RD_NONE, 16'h5000, 8'h00, 8'hFF, SEL_NONE);
endtask

// File: test/asic_registers_tb.sv
module asic_registers_tb;
    import asic_pkg::*;

    typedef enum {OP_WR, OP_WR_ECHO, OP_RD, OP_RD_NONE, OP_CHK, OP_SELECTS} op_e;
    typedef enum {SEL_NONE, SEL_ROM_CFG, SEL_RAM_CFG, SEL_ROM_SEL, SEL_PEN, SEL_INK,
                  SEL_SELECT, SEL_CRTC, SEL_UNLOCK} sel_e;

    localparam int READ_TIMEOUT = 20;  // Cycles to wait for the read enable

    logic       clk_sys;
    logic       reset;
    addr_t      cpu_addr;
    byte_t      cpu_data_in;
    logic       cpu_wr;
    logic       cpu_rd;
    byte_t      cpu_data_out;
    logic       cpu_data_out_en;
    byte_t      asic_data_out;
    logic       asic_data_out_en;
    byte_t      ram_config;
    byte_t      rom_config;
    byte_t      rom_select;
    pen_t       current_pen;
    pen_t       pen_ink;
    byte_t      crtc_select;
    crtc_file_t crtc_file;
    logic       acid_unlocked;

    // Table columns
    string names[$];
    op_e   ops[$];
    addr_t addrs[$];
    byte_t datas[$];
    byte_t expects[$];
    sel_e  sels[$];

    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;
    int select_cursor;  // Next entry of SELECT_BYTES

    asic_registers UUT (.*);

    initial begin
        clk_sys = 1'b0;
        forever #20 clk_sys = ~clk_sys;
    end

    task automatic add_row(string name, op_e op, addr_t addr, byte_t data,
                           byte_t expected, sel_e sel);
        names.push_back(name);
        ops.push_back(op);
        addrs.push_back(addr);
        datas.push_back(data);
        expects.push_back(expected);
        sels.push_back(sel);
    endtask

    `include "asic_vectors.svh"

    task automatic check_value(string name, byte_t expected, byte_t actual);
        assert (actual == expected) else begin
            $display("[FAIL] %s expected %02h actual %02h", name, expected, actual);
            test_errors++;
        end
    endtask

    function automatic byte_t output_value(sel_e sel, addr_t index);
        case (sel)
            SEL_ROM_CFG: return rom_config;
            SEL_RAM_CFG: return ram_config;
            SEL_ROM_SEL: return rom_select;
            SEL_PEN:     return {3'b000, current_pen};
            SEL_INK:     return {3'b000, pen_ink};
            SEL_SELECT:  return crtc_select;
            SEL_CRTC:    return crtc_file[index[4:0]];
            SEL_UNLOCK:  return {7'b0000000, acid_unlocked};
            default:     return 8'hFF;
        endcase
    endfunction

    // Called and returns on a falling edge
    task automatic bus_write(addr_t addr, byte_t data);
        cpu_addr    = addr;
        cpu_data_in = data;
        cpu_wr      = 1'b1;
        @(negedge clk_sys);
        cpu_wr = 1'b0;
    endtask

    task automatic bus_read(addr_t addr, output byte_t value, output logic seen);
        int waited;
        cpu_addr = addr;
        cpu_rd   = 1'b1;
        @(negedge clk_sys);
        cpu_rd = 1'b0;
        waited = 0;
        while (!cpu_data_out_en && waited < READ_TIMEOUT) begin
            @(negedge clk_sys);
            waited++;
        end
        seen  = cpu_data_out_en;
        value = cpu_data_out;
    endtask

    task automatic apply_row(int i);
        byte_t value;
        logic  seen;
        case (ops[i])
            OP_WR: bus_write(addrs[i], datas[i]);
            OP_WR_ECHO: begin
                bus_write(addrs[i], datas[i]);
                assert (asic_data_out_en) else begin
                    $display("%s: no CRTC echo after the write to %04h", names[i], addrs[i]);
                    test_errors++;
                end
                check_value(names[i], expects[i], asic_data_out);
            end
            OP_RD: begin
                bus_read(addrs[i], value, seen);
                assert (seen) else begin
                    $display("%s: read of %04h timed out without a data enable",
                             names[i], addrs[i]);
                    test_errors++;
                end
                check_value(names[i], expects[i], value);
            end
            OP_RD_NONE: begin
                bus_read(addrs[i], value, seen);
                assert (!seen) else begin
                    $display("%s: read of unmapped %04h raised the data enable",
                             names[i], addrs[i]);
                    test_errors++;
                end
                check_value(names[i], expects[i], value);
            end
            OP_CHK: check_value(names[i], expects[i], output_value(sels[i], addrs[i]));
            OP_SELECTS: begin
                for (int n = 0; n < int'(datas[i]); n++) begin
                    bus_write(addrs[i], SELECT_BYTES[select_cursor]);
                    select_cursor++;
                end
            end
            default: ;
        endcase
    endtask

    task automatic finish_test(string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin
        string current;
        reset         = 1'b1;
        cpu_addr      = '0;
        cpu_data_in   = '0;
        cpu_wr        = 1'b0;
        cpu_rd        = 1'b0;
        errors        = 0;
        test_errors   = 0;
        tests_run     = 0;
        tests_failed  = 0;
        select_cursor = 0;
        build_table();

        repeat (4) @(posedge clk_sys);
        @(negedge clk_sys);
        reset = 1'b0;
        @(negedge clk_sys);

        current = names[0];
        for (int i = 0; i < names.size(); i++) begin
            if (names[i] != current) begin
                finish_test(current);
                current = names[i];
            end
            apply_row(i);
        end
        finish_test(current);

        $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+test
verilog/asic_pkg.sv
verilog/asic_bus_decode.sv
verilog/acid_unlock.sv
verilog/crtc_regs.sv
verilog/gate_array_regs.sv
verilog/asic_page_regs.sv
verilog/asic_registers.sv
test/asic_registers_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module asic_registers_tb \
    -f flist.f -o asic_registers_sim

./obj_dir/asic_registers_sim | tee sim.log

if grep -q "Test completed successfully" sim.log; then
    exit 0
fi
exit 1
